/* hdl/cpu_frontend_pkg.sv */
package cpu_frontend_pkg;

	// Data and address width
	localparam int xlen = 32;

	// Width of the delivered instruction counter
	localparam int fetch_tag_width = 8;

	// Default number of one-word cache slots
	localparam int line_count_default = 8;

	typedef logic [4:0] reg_index_t;

	// RV32 major opcodes seen by the front end
	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_op_imm = 7'b0010011,
		op_op     = 7'b0110011,
		op_system = 7'b1110011
	} opcode_t;

	// Packet handed from fetch to decode
	typedef struct packed {
		logic [fetch_tag_width-1:0] tag;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] instruction;
		reg_index_t rs1;
		reg_index_t rs2;
	} fetch_data_t;

endpackage

/* hdl/cpu_frontend_if.sv */
`timescale 1ns/10ps

// Fetch unit to cache lookup path
interface icache_lookup_if;
	import cpu_frontend_pkg::*;

	logic [xlen-1:0] pc;
	logic stall;
	logic ready;
	logic [xlen-1:0] rdata;

	modport requester (
		output pc,
		output stall,
		input ready,
		input rdata
	);

	modport responder (
		input pc,
		input stall,
		output ready,
		output rdata
	);

	// Slots and refill engine only look at the pc
	modport monitor (
		input pc
	);

endinterface

// Refill engine to cache slots
interface icache_fill_if #(
	parameter int line_count = cpu_frontend_pkg::line_count_default
);
	import cpu_frontend_pkg::*;

	localparam int index_width = $clog2(line_count);
	localparam int tag_width = xlen - 2 - index_width;

	logic write;
	logic [index_width-1:0] index;
	logic [tag_width-1:0] tag;
	logic [xlen-1:0] word;

	modport writer (
		output write,
		output index,
		output tag,
		output word
	);

	modport slot (
		input write,
		input index,
		input tag,
		input word
	);

endinterface

/* hdl/icache_line.sv */
`timescale 1ns/10ps

module icache_line #(
	parameter int line_count = cpu_frontend_pkg::line_count_default,
	parameter int slot = 0
)(
	input logic i_clock,
	input logic i_reset,
	icache_fill_if.slot fill,
	icache_lookup_if.monitor lookup,
	output logic o_hit,
	output logic [cpu_frontend_pkg::xlen-1:0] o_word
);
	import cpu_frontend_pkg::*;

	localparam int index_width = $clog2(line_count);
	localparam int tag_width = xlen - 2 - index_width;
	localparam logic [index_width-1:0] slot_index = index_width'(slot);

	logic valid;
	logic [tag_width-1:0] line_tag;
	logic [xlen-1:0] line_word;
	logic write_here;

	// Only the addressed slot takes the refill
	assign write_here = fill.write && (fill.index == slot_index);

	always_ff @(posedge i_clock) begin
		if (i_reset)
			valid <= 1'b0;
		else if (write_here)
			valid <= 1'b1;
	end

	always_ff @(posedge i_clock) begin
		if (write_here) begin
			line_tag <= fill.tag;
			line_word <= fill.word;
		end
	end

	assign o_hit = valid
		&& (lookup.pc[index_width+1:2] == slot_index)
		&& (lookup.pc[xlen-1:index_width+2] == line_tag);
	assign o_word = line_word;

endmodule

/* hdl/icache_refill.sv */
`timescale 1ns/10ps

module icache_refill #(
	parameter int line_count = cpu_frontend_pkg::line_count_default
)(
	input logic i_clock,
	input logic i_reset,
	icache_lookup_if.monitor lookup,
	input logic i_hit_any,
	icache_fill_if.writer fill,

	// External bus
	output logic o_bus_request,
	output logic [cpu_frontend_pkg::xlen-1:0] o_bus_address,
	input logic i_bus_ready,
	input logic [cpu_frontend_pkg::xlen-1:0] i_bus_rdata
);
	import cpu_frontend_pkg::*;

	localparam int index_width = $clog2(line_count);

	typedef enum logic [1:0] {
		refill_idle,
		refill_request,
		refill_write
	} refill_state_t;

	refill_state_t state;
	logic [xlen-1:0] miss_pc;
	logic [xlen-1:0] miss_word;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= refill_idle;
			o_bus_request <= 1'b0;
		end
		else begin
			case (state)
				refill_idle: begin
					if (!i_hit_any) begin
						o_bus_request <= 1'b1;
						state <= refill_request;
					end
				end
				refill_request: begin
					// Request held until the bus answers
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						state <= refill_write;
					end
				end
				refill_write:
					state <= refill_idle;
				default:
					state <= refill_idle;
			endcase
		end
	end

	// Address and data of the line being refilled
	always_ff @(posedge i_clock) begin
		if (state == refill_idle && !i_hit_any)
			miss_pc <= {lookup.pc[xlen-1:2], 2'b00};
		if (state == refill_request && i_bus_ready)
			miss_word <= i_bus_rdata;
	end

	assign o_bus_address = miss_pc;

	assign fill.write = (state == refill_write);
	assign fill.index = miss_pc[index_width+1:2];
	assign fill.tag = miss_pc[xlen-1:index_width+2];
	assign fill.word = miss_word;

endmodule

/* hdl/icache_hit_select.sv */
`timescale 1ns/10ps

module icache_hit_select #(
	parameter int line_count = cpu_frontend_pkg::line_count_default
)(
	input logic [line_count-1:0] i_hit,
	input logic [line_count-1:0][cpu_frontend_pkg::xlen-1:0] i_words,
	icache_lookup_if.responder lookup,
	output logic o_hit_any
);
	import cpu_frontend_pkg::*;

	logic [xlen-1:0] hit_word;

	// At most one slot can match a given pc
	always_comb begin
		hit_word = '0;
		for (int i = 0; i < line_count; i++) begin
			hit_word = hit_word | ({xlen{i_hit[i]}} & i_words[i]);
		end
	end

	assign o_hit_any = |i_hit;

	// Stall holds back the answer, not the lookup
	assign lookup.ready = o_hit_any && !lookup.stall;
	assign lookup.rdata = hit_word;

endmodule

/* hdl/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit #(
	parameter logic [cpu_frontend_pkg::xlen-1:0] reset_vector = '0
)(
	input logic i_clock,
	input logic i_reset,
	icache_lookup_if.requester lookup,

	// Redirect from execute
	input logic i_jump,
	input logic [cpu_frontend_pkg::xlen-1:0] i_jump_pc,

	// Interrupt
	input logic i_irq_pending,
	input logic [cpu_frontend_pkg::xlen-1:0] i_irq_pc,
	output logic o_irq_dispatched,
	output logic [cpu_frontend_pkg::xlen-1:0] o_irq_epc,

	// Decode side
	input logic i_decode_busy,
	output cpu_frontend_pkg::fetch_data_t o_data
);
	import cpu_frontend_pkg::*;

	typedef enum logic {
		wait_icache,
		wait_jump
	} fetch_state_t;

	fetch_state_t state;
	logic [xlen-1:0] pc;
	fetch_data_t data_current;
	fetch_data_t data_held;

	opcode_t opcode;
	logic have_rs1;
	logic have_rs2;
	logic stops_fetch;

	// Classify the word coming out of the cache
	always_comb begin
		opcode = opcode_t'(lookup.rdata[6:0]);
		have_rs1 = 1'b0;
		have_rs2 = 1'b0;
		stops_fetch = 1'b0;
		case (opcode)
			op_lui, op_auipc: ;
			op_jal:
				stops_fetch = 1'b1;
			op_jalr: begin
				have_rs1 = 1'b1;
				stops_fetch = 1'b1;
			end
			op_branch: begin
				have_rs1 = 1'b1;
				have_rs2 = 1'b1;
				stops_fetch = 1'b1;
			end
			op_load, op_op_imm:
				have_rs1 = 1'b1;
			op_store, op_op: begin
				have_rs1 = 1'b1;
				have_rs2 = 1'b1;
			end
			// ECALL, MRET and WFI all wait for execute
			op_system: begin
				have_rs1 = 1'b1;
				stops_fetch = 1'b1;
			end
			default: ;
		endcase
	end

	assign lookup.pc = pc;
	assign lookup.stall = i_decode_busy || (state != wait_icache);

	// Decode sees the held copy while it is busy
	assign o_data = i_decode_busy ? data_held : data_current;

	always_ff @(posedge i_clock) begin
		if (i_reset)
			data_held <= '0;
		else if (!i_decode_busy)
			data_held <= data_current;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= wait_icache;
			pc <= reset_vector;
			data_current <= '0;
			o_irq_dispatched <= 1'b0;
			o_irq_epc <= '0;
		end
		else begin
			o_irq_dispatched <= 1'b0;
			o_irq_epc <= '0;
			if (i_irq_pending) begin
				// Interrupt wins over any fetch in flight
				o_irq_dispatched <= 1'b1;
				o_irq_epc <= pc;
				pc <= i_irq_pc;
				state <= wait_icache;
			end
			else begin
				case (state)
					wait_icache: begin
						if (lookup.ready) begin
							data_current.tag <= data_current.tag + 1'b1;
							data_current.pc <= pc;
							data_current.instruction <= lookup.rdata;
							data_current.rs1 <= have_rs1 ? lookup.rdata[19:15] : '0;
							data_current.rs2 <= have_rs2 ? lookup.rdata[24:20] : '0;
							if (stops_fetch)
								state <= wait_jump;
							else
								pc <= pc + 32'd4;
						end
					end
					wait_jump: begin
						if (i_jump) begin
							pc <= i_jump_pc;
							state <= wait_icache;
						end
					end
					default:
						state <= wait_icache;
				endcase
			end
		end
	end

endmodule

/* hdl/cpu_frontend.sv */
`timescale 1ns/10ps

module cpu_frontend #(
	parameter logic [cpu_frontend_pkg::xlen-1:0] reset_vector = 32'h0000_0000,
	parameter int line_count = cpu_frontend_pkg::line_count_default
)(
	input logic i_clock,
	input logic i_reset,

	input logic i_jump,
	input logic [cpu_frontend_pkg::xlen-1:0] i_jump_pc,

	input logic i_irq_pending,
	input logic [cpu_frontend_pkg::xlen-1:0] i_irq_pc,
	output logic o_irq_dispatched,
	output logic [cpu_frontend_pkg::xlen-1:0] o_irq_epc,

	output logic o_bus_request,
	output logic [cpu_frontend_pkg::xlen-1:0] o_bus_address,
	input logic i_bus_ready,
	input logic [cpu_frontend_pkg::xlen-1:0] i_bus_rdata,

	input logic i_decode_busy,
	output logic [cpu_frontend_pkg::fetch_tag_width-1:0] o_fetch_tag,
	output logic [cpu_frontend_pkg::xlen-1:0] o_fetch_pc,
	output logic [cpu_frontend_pkg::xlen-1:0] o_fetch_instruction,
	output cpu_frontend_pkg::reg_index_t o_fetch_rs1,
	output cpu_frontend_pkg::reg_index_t o_fetch_rs2
);
	import cpu_frontend_pkg::*;

	fetch_data_t fetch_data;
	logic [line_count-1:0] line_hit;
	logic [line_count-1:0][xlen-1:0] line_word;
	logic hit_any;

	icache_lookup_if lookup();
	icache_fill_if #(.line_count(line_count)) fill();

	fetch_unit #(
		.reset_vector(reset_vector)
	) i_fetch_unit (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.lookup(lookup.requester),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.i_decode_busy(i_decode_busy),
		.o_data(fetch_data)
	);

	icache_refill #(
		.line_count(line_count)
	) i_icache_refill (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.lookup(lookup.monitor),
		.i_hit_any(hit_any),
		.fill(fill.writer),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

	icache_hit_select #(
		.line_count(line_count)
	) i_icache_hit_select (
		.i_hit(line_hit),
		.i_words(line_word),
		.lookup(lookup.responder),
		.o_hit_any(hit_any)
	);

	// One slot per cache index
	for (genvar i = 0; i < line_count; i++) begin : g_line
		icache_line #(
			.line_count(line_count),
			.slot(i)
		) i_icache_line (
			.i_clock(i_clock),
			.i_reset(i_reset),
			.fill(fill.slot),
			.lookup(lookup.monitor),
			.o_hit(line_hit[i]),
			.o_word(line_word[i])
		);
	end

	assign o_fetch_tag = fetch_data.tag;
	assign o_fetch_pc = fetch_data.pc;
	assign o_fetch_instruction = fetch_data.instruction;
	assign o_fetch_rs1 = fetch_data.rs1;
	assign o_fetch_rs2 = fetch_data.rs2;

endmodule

/* verification/frontend_checker.sv */
`timescale 1ns/10ps

module frontend_checker #(
	parameter int steps = 1
)(
	input logic i_clock,
	input logic i_reset,
	input logic i_done,
	input logic [31:0] i_step_address [steps],
	input logic [31:0] i_step_instruction [steps],
	input logic i_step_irq [steps],
	input logic i_step_miss [steps],
	input logic i_decode_busy,
	input logic i_bus_request,
	input logic i_irq_dispatched,
	input logic [31:0] i_irq_epc,
	input logic [7:0] i_fetch_tag,
	input logic [31:0] i_fetch_pc,
	input logic [31:0] i_fetch_instruction,
	input logic [4:0] i_fetch_rs1,
	input logic [4:0] i_fetch_rs2,
	output int o_error_count,
	output int o_check_count
);
	import cpu_frontend_pkg::*;

	int error_count = 0;
	int check_count = 0;
	int packet_index;
	int request_edges;
	int irq_count;
	int irq_expected;
	logic done_seen;
	logic last_request;
	logic last_busy;
	logic last_irq;
	logic [7:0] last_tag;
	logic [31:0] last_pc;
	logic [31:0] last_instruction;
	logic [9:0] last_sources;
	logic [9:0] sources;

	assign o_error_count = error_count;
	assign o_check_count = check_count;

	// Register fields the format really has, per RV32 base formats
	function automatic logic [9:0] expected_sources(input logic [31:0] instruction);
		opcode_t op;
		logic [4:0] rs1;
		logic [4:0] rs2;
		op = opcode_t'(instruction[6:0]);
		rs1 = '0;
		rs2 = '0;
		case (op)
			op_jalr, op_load, op_op_imm, op_system:
				rs1 = instruction[19:15];
			op_branch, op_store, op_op: begin
				rs1 = instruction[19:15];
				rs2 = instruction[24:20];
			end
			default: ;
		endcase
		return {rs1, rs2};
	endfunction

	task automatic report_mismatch(input string message);
		error_count++;
		$display("** Error at %0t: %s", $time, message);
	endtask

	always @(negedge i_clock) begin
		sources = {i_fetch_rs1, i_fetch_rs2};
		if (i_reset) begin
			check_count++;
			if (i_bus_request || i_irq_dispatched || i_irq_epc != '0 || i_fetch_tag != '0
				|| i_fetch_pc != '0 || i_fetch_instruction != '0 || sources != '0)
				report_mismatch("outputs not cleared in reset");
			packet_index = 0;
			request_edges = 0;
			irq_count = 0;
			done_seen = 1'b0;
		end
		else begin
			if (i_bus_request && !last_request)
				request_edges++;
			// Held packet must not move while decode is busy
			if (last_busy && i_decode_busy) begin
				check_count++;
				if (i_fetch_tag != last_tag || i_fetch_pc != last_pc
					|| i_fetch_instruction != last_instruction || sources != last_sources)
					report_mismatch("packet changed while decode busy");
			end
			if (i_fetch_tag != last_tag) begin
				check_count++;
				if (packet_index >= steps)
					report_mismatch("packet beyond end of program");
				else begin
					if (i_fetch_tag != last_tag + 8'd1)
						report_mismatch($sformatf("tag %0d follows %0d", i_fetch_tag, last_tag));
					if (i_fetch_pc != i_step_address[packet_index])
						report_mismatch($sformatf("pc %h, expected %h", i_fetch_pc,
							i_step_address[packet_index]));
					if (i_fetch_instruction != i_step_instruction[packet_index])
						report_mismatch($sformatf("instruction %h at pc %h", i_fetch_instruction,
							i_fetch_pc));
					if (sources != expected_sources(i_step_instruction[packet_index]))
						report_mismatch($sformatf("rs1/rs2 %0d/%0d at pc %h", i_fetch_rs1,
							i_fetch_rs2, i_fetch_pc));
					if (request_edges != int'(i_step_miss[packet_index]))
						report_mismatch($sformatf("%0d bus requests before pc %h",
							request_edges, i_fetch_pc));
				end
				packet_index++;
				request_edges = 0;
			end
			if (i_irq_dispatched) begin
				check_count++;
				irq_count++;
				if (last_irq)
					report_mismatch("dispatch pulse longer than one cycle");
				else if (packet_index == 0 || !i_step_irq[packet_index-1])
					report_mismatch("unexpected interrupt dispatch");
				else if (i_irq_epc != i_step_address[packet_index-1])
					report_mismatch($sformatf("epc %h, expected %h", i_irq_epc,
						i_step_address[packet_index-1]));
			end
			if (i_done && !done_seen) begin
				done_seen = 1'b1;
				irq_expected = 0;
				for (int i = 0; i < steps; i++)
					irq_expected += int'(i_step_irq[i]);
				check_count++;
				if (packet_index != steps)
					report_mismatch($sformatf("%0d packets, expected %0d", packet_index, steps));
				if (irq_count != irq_expected)
					report_mismatch($sformatf("%0d dispatches, expected %0d", irq_count,
						irq_expected));
			end
		end
		last_request = i_bus_request;
		last_busy = i_decode_busy;
		last_irq = i_irq_dispatched;
		last_tag = i_fetch_tag;
		last_pc = i_fetch_pc;
		last_instruction = i_fetch_instruction;
		last_sources = sources;
	end

endmodule

/* verification/tb_cpu_frontend.sv */
`timescale 1ns/10ps

module tb_cpu_frontend;
	import cpu_frontend_pkg::*;

	localparam int steps = 22;
	localparam int wait_limit = 200;

	logic i_clock;
	logic i_reset;
	logic i_jump;
	logic [31:0] i_jump_pc;
	logic i_irq_pending;
	logic [31:0] i_irq_pc;
	logic o_irq_dispatched;
	logic [31:0] o_irq_epc;
	logic o_bus_request;
	logic [31:0] o_bus_address;
	logic i_bus_ready;
	logic [31:0] i_bus_rdata;
	logic i_decode_busy;
	logic [7:0] o_fetch_tag;
	logic [31:0] o_fetch_pc;
	logic [31:0] o_fetch_instruction;
	logic [4:0] o_fetch_rs1;
	logic [4:0] o_fetch_rs2;
	logic done;

	// Program table, one row per delivered packet
	logic [31:0] step_address [steps];
	logic [31:0] step_instruction [steps];
	logic [31:0] step_target [steps];
	logic step_irq [steps];
	logic step_busy [steps];
	logic step_miss [steps];
	int step_fill;
	int timeout_count;
	int error_count;
	int check_count;
	logic [31:0] memory_seed = 32'h02ea35d7;
	logic [31:0] busy_seed = 32'h02ea35d7;

	always #2 i_clock = ~i_clock;

	cpu_frontend #(
		.reset_vector(32'h0000_0100),
		.line_count(8)
	) i_cpu_frontend (.*);

	frontend_checker #(
		.steps(steps)
	) i_frontend_checker (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_done(done),
		.i_step_address(step_address),
		.i_step_instruction(step_instruction),
		.i_step_irq(step_irq),
		.i_step_miss(step_miss),
		.i_decode_busy(i_decode_busy),
		.i_bus_request(o_bus_request),
		.i_irq_dispatched(o_irq_dispatched),
		.i_irq_epc(o_irq_epc),
		.i_fetch_tag(o_fetch_tag),
		.i_fetch_pc(o_fetch_pc),
		.i_fetch_instruction(o_fetch_instruction),
		.i_fetch_rs1(o_fetch_rs1),
		.i_fetch_rs2(o_fetch_rs2),
		.o_error_count(error_count),
		.o_check_count(check_count)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] s;
		s = state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Unknown addresses read as a NOP
	function automatic logic [31:0] memory_word(input logic [31:0] address);
		for (int i = 0; i < steps; i++) begin
			if (step_address[i] == address)
				return step_instruction[i];
		end
		return 32'h0000_0013;
	endfunction

	// Jumps, branches and SYSTEM wait for execute
	function automatic logic redirects(input logic [31:0] instruction);
		case (instruction[6:0])
			7'h6f, 7'h67, 7'h63, 7'h73: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	task automatic add_step(input logic [31:0] address, input logic [31:0] instruction,
		input logic [31:0] target, input logic irq, input logic busy, input logic miss);
		step_address[step_fill] = address;
		step_instruction[step_fill] = instruction;
		step_target[step_fill] = target;
		step_irq[step_fill] = irq;
		step_busy[step_fill] = busy;
		step_miss[step_fill] = miss;
		step_fill++;
	endtask

	// Tag is looked at on the falling edge, then back to the drive point
	task automatic wait_for_tag(input logic [7:0] tag);
		int cycles;
		cycles = 0;
		@(negedge i_clock);
		while (o_fetch_tag != tag && cycles < wait_limit) begin
			@(negedge i_clock);
			cycles++;
		end
		if (o_fetch_tag != tag) begin
			timeout_count++;
			$display("Timeout: fetch tag %0d never appeared", tag);
		end
		@(posedge i_clock);
		#0.5;
	endtask

	// Bus slave with 1 to 4 cycles of latency
	always begin : memory_model
		int delay;
		@(posedge i_clock);
		#0.5;
		if (o_bus_request && !i_reset) begin
			memory_seed = xorshift(memory_seed);
			delay = int'(memory_seed[1:0]) + 1;
			repeat (delay - 1) begin
				@(posedge i_clock);
				#0.5;
			end
			i_bus_rdata = memory_word(o_bus_address);
			i_bus_ready = 1'b1;
			@(posedge i_clock);
			#0.5;
			i_bus_ready = 1'b0;
			i_bus_rdata = '0;
		end
	end

	initial begin : stimulus
		int busy_cycles;
		i_clock = 1'b0;
		i_reset = 1'b1;
		i_jump = 1'b0;
		i_jump_pc = '0;
		i_irq_pending = 1'b0;
		i_irq_pc = '0;
		i_bus_ready = 1'b0;
		i_bus_rdata = '0;
		i_decode_busy = 1'b0;
		done = 1'b0;
		timeout_count = 0;
		step_fill = 0;
		// Straight line, then a loop served from the cache
		add_step(32'h100, 32'h000010b7, 32'h0, 1'b0, 1'b0, 1'b1);
		add_step(32'h104, 32'h00508113, 32'h0, 1'b0, 1'b0, 1'b1);
		add_step(32'h108, 32'h002081b3, 32'h0, 1'b0, 1'b1, 1'b1);
		add_step(32'h10c, 32'h00312023, 32'h0, 1'b0, 1'b0, 1'b1);
		add_step(32'h110, 32'h00012203, 32'h0, 1'b0, 1'b1, 1'b1);
		add_step(32'h114, 32'h00208063, 32'h100, 1'b0, 1'b0, 1'b1);
		add_step(32'h100, 32'h000010b7, 32'h0, 1'b0, 1'b1, 1'b0);
		add_step(32'h104, 32'h00508113, 32'h0, 1'b0, 1'b0, 1'b0);
		add_step(32'h108, 32'h002081b3, 32'h0, 1'b0, 1'b1, 1'b0);
		add_step(32'h10c, 32'h00312023, 32'h0, 1'b0, 1'b1, 1'b0);
		add_step(32'h110, 32'h00012203, 32'h0, 1'b0, 1'b0, 1'b0);
		add_step(32'h114, 32'h00208063, 32'h180, 1'b0, 1'b1, 1'b0);
		// 0x180, 0x200 and 0x300 all land on slot 0, 0x204 on slot 1
		add_step(32'h180, 32'h0000006f, 32'h200, 1'b0, 1'b0, 1'b1);
		add_step(32'h200, 32'h00000297, 32'h0, 1'b0, 1'b1, 1'b1);
		add_step(32'h204, 32'h10500073, 32'h300, 1'b1, 1'b0, 1'b1);
		add_step(32'h300, 32'h00008067, 32'h100, 1'b0, 1'b0, 1'b1);
		add_step(32'h100, 32'h000010b7, 32'h0, 1'b0, 1'b0, 1'b1);
		add_step(32'h104, 32'h00508113, 32'h0, 1'b0, 1'b1, 1'b1);
		add_step(32'h108, 32'h002081b3, 32'h0, 1'b0, 1'b0, 1'b0);
		add_step(32'h10c, 32'h00312023, 32'h0, 1'b0, 1'b1, 1'b0);
		add_step(32'h110, 32'h00012203, 32'h0, 1'b0, 1'b0, 1'b0);
		add_step(32'h114, 32'h00208063, 32'h0, 1'b0, 1'b0, 1'b0);

		repeat (8) @(posedge i_clock);
		#0.5;
		i_reset = 1'b0;

		for (int k = 0; k < steps; k++) begin
			wait_for_tag(8'(k + 1));
			if (step_busy[k]) begin
				// Busy starts in the cycle after the packet was seen
				busy_seed = xorshift(busy_seed);
				busy_cycles = int'(busy_seed[2:0]) + 1;
				i_decode_busy = 1'b1;
				repeat (busy_cycles) begin
					@(posedge i_clock);
					#0.5;
				end
				i_decode_busy = 1'b0;
			end
			if (k < steps - 1 && redirects(step_instruction[k])) begin
				if (step_irq[k]) begin
					i_irq_pc = step_target[k];
					i_irq_pending = 1'b1;
				end
				else begin
					i_jump_pc = step_target[k];
					i_jump = 1'b1;
				end
				@(posedge i_clock);
				#0.5;
				i_irq_pending = 1'b0;
				i_jump = 1'b0;
			end
		end

		@(posedge i_clock);
		#0.5;
		done = 1'b1;
		@(negedge i_clock);
		@(posedge i_clock);
		$display("Checks %0d, errors %0d, timeouts %0d", check_count, error_count,
			timeout_count);
		if (error_count == 0 && timeout_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* compile.f */
hdl/cpu_frontend_pkg.sv
hdl/cpu_frontend_if.sv
hdl/icache_line.sv
hdl/icache_refill.sv
hdl/icache_hit_select.sv
hdl/fetch_unit.sv
hdl/cpu_frontend.sv
verification/frontend_checker.sv
verification/tb_cpu_frontend.sv

/* Makefile */
# Verilator build and run of the instruction front end testbench

VERILATOR ?= verilator
TOP ?= tb_cpu_frontend
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
PASS_TEXT ?= Done: no errors

BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

$(BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(BIN)
	@./$(BIN) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
